// ==== common/csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // register numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    // entry address is 64-byte aligned
    localparam int EENTRY_ALIGN_BITS = 6;
    localparam int TIMER_BITS        = 32;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // one write word read through the layout its address selects
    typedef union packed {
        csr_data_t raw;
        crmd_t     crmd;
        prmd_t     prmd;
        tcfg_t     tcfg;
    } csr_word_u;

endpackage

// ==== common/excp_pkg.sv ====
package excp_pkg;

    typedef logic [1:0] plv_t;
    typedef logic [5:0] ecode_t;

    // sw[1:0], hw[9:2], timer 11, ipi 12
    typedef logic [12:0] int_vec_t;

    localparam int INT_SW_LO = 0;
    localparam int INT_HW_LO = 2;
    localparam int INT_TIMER = 11;

endpackage

// ==== csr/csr_bank.sv ====
`timescale 1ns/1ps

module csr_bank (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_word_u  wr_data,
    input  csr_pkg::csr_addr_t  rd_addr,

    input  logic                excp_flush,
    input  excp_pkg::ecode_t    excp_code,
    input  csr_pkg::csr_data_t  era_in,
    input  logic                ertn_flush,

    input  excp_pkg::int_vec_t  estat_is,

    output csr_pkg::csr_data_t  bank_rd_data,
    output logic [1:0]          sw_int,
    output excp_pkg::int_vec_t  ecfg_lie,
    output logic                crmd_ie,
    output excp_pkg::plv_t      plv_out,
    output csr_pkg::csr_data_t  era_out,
    output csr_pkg::csr_data_t  eentry_out
);

    excp_pkg::plv_t     crmd_plv;
    excp_pkg::plv_t     prmd_pplv;
    logic               prmd_pie;
    excp_pkg::ecode_t   estat_ecode;
    csr_pkg::csr_data_t era_q;
    logic [31:csr_pkg::EENTRY_ALIGN_BITS] eentry_q;
    csr_pkg::csr_data_t save_q [4];

    // flush beats a same-cycle write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (excp_flush) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_en) begin
            if (wr_addr == csr_pkg::CSR_CRMD) begin
                crmd_plv <= wr_data.crmd.plv;
                crmd_ie  <= wr_data.crmd.ie;
            end
            if (wr_addr == csr_pkg::CSR_PRMD) begin
                prmd_pplv <= wr_data.prmd.pplv;
                prmd_pie  <= wr_data.prmd.pie;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            estat_ecode <= '0;
            era_q       <= '0;
        end else if (excp_flush) begin
            estat_ecode <= excp_code;
            era_q       <= era_in;
        end else if (wr_en && wr_addr == csr_pkg::CSR_ERA) begin
            era_q <= wr_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ecfg_lie <= '0;
            sw_int   <= '0;
            eentry_q <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_en) begin
            case (wr_addr)
                csr_pkg::CSR_ECFG:   ecfg_lie <= wr_data.raw[12:0];
                // only the software bits of ESTAT are writable
                csr_pkg::CSR_ESTAT:  sw_int <= wr_data.raw[excp_pkg::INT_SW_LO +: 2];
                csr_pkg::CSR_EENTRY: eentry_q <= wr_data.raw[31:csr_pkg::EENTRY_ALIGN_BITS];
                csr_pkg::CSR_SAVE0:  save_q[0] <= wr_data.raw;
                csr_pkg::CSR_SAVE1:  save_q[1] <= wr_data.raw;
                csr_pkg::CSR_SAVE2:  save_q[2] <= wr_data.raw;
                csr_pkg::CSR_SAVE3:  save_q[3] <= wr_data.raw;
                default: ;
            endcase
        end
    end

    assign plv_out    = crmd_plv;
    assign era_out    = era_q;
    assign eentry_out = {eentry_q, {csr_pkg::EENTRY_ALIGN_BITS{1'b0}}};

    always_comb begin
        case (rd_addr)
            csr_pkg::CSR_CRMD:   bank_rd_data = {29'b0, crmd_ie, crmd_plv};
            csr_pkg::CSR_PRMD:   bank_rd_data = {29'b0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   bank_rd_data = {19'b0, ecfg_lie};
            // code in 21:16, status in 12:0
            csr_pkg::CSR_ESTAT:  bank_rd_data = {10'b0, estat_ecode, 3'b0, estat_is};
            csr_pkg::CSR_ERA:    bank_rd_data = era_q;
            csr_pkg::CSR_EENTRY: bank_rd_data = eentry_out;
            csr_pkg::CSR_SAVE0:  bank_rd_data = save_q[0];
            csr_pkg::CSR_SAVE1:  bank_rd_data = save_q[1];
            csr_pkg::CSR_SAVE2:  bank_rd_data = save_q[2];
            csr_pkg::CSR_SAVE3:  bank_rd_data = save_q[3];
            default:             bank_rd_data = '0;
        endcase
    end

endmodule

// ==== csr/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_word_u  wr_data,
    input  csr_pkg::csr_addr_t  rd_addr,

    output csr_pkg::csr_data_t  timer_rd_data,
    output logic                timer_pending,
    output logic [63:0]         timer_64_out,
    output csr_pkg::csr_data_t  tid_out
);

    csr_pkg::csr_word_u                 tcfg_q;
    logic [csr_pkg::TIMER_BITS-1:0]     tval_q;
    logic [csr_pkg::TIMER_BITS-1:0]     reload_val;
    logic                               tcfg_wr;
    logic                               timer_fire;

    assign tcfg_wr    = wr_en && (wr_addr == csr_pkg::CSR_TCFG);
    assign reload_val = tcfg_q.tcfg.periodic ? {tcfg_q.tcfg.initval, 2'b00} : '0;
    // last count before zero
    assign timer_fire = tcfg_q.tcfg.en && (tval_q == 1) && !tcfg_wr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_64_out <= '0;
        end else begin
            timer_64_out <= timer_64_out + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tid_out <= '0;
        end else if (wr_en && wr_addr == csr_pkg::CSR_TID) begin
            tid_out <= wr_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tcfg_q <= '0;
            tval_q <= '0;
        end else if (tcfg_wr) begin
            tcfg_q <= wr_data;
            if (wr_data.tcfg.en) begin
                tval_q <= {wr_data.tcfg.initval, 2'b00};
            end
        end else if (timer_fire) begin
            tval_q <= reload_val;
        end else if (tcfg_q.tcfg.en && tval_q != '0) begin
            tval_q <= tval_q - 1;
        end
    end

    // a fire in the same cycle wins over the clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_pending <= 1'b0;
        end else if (timer_fire) begin
            timer_pending <= 1'b1;
        end else if (wr_en && wr_addr == csr_pkg::CSR_TICLR && wr_data.raw[0]) begin
            timer_pending <= 1'b0;
        end
    end

    always_comb begin
        case (rd_addr)
            csr_pkg::CSR_TID:  timer_rd_data = tid_out;
            csr_pkg::CSR_TCFG: timer_rd_data = tcfg_q.raw;
            csr_pkg::CSR_TVAL: timer_rd_data = tval_q;
            default:           timer_rd_data = '0;
        endcase
    end

endmodule

// ==== rtl/csr_int_unit.sv ====
`timescale 1ns/1ps

module csr_int_unit (
    input  logic                clk,
    input  logic                rst_n,

    input  logic [7:0]          interrupt,
    input  logic [1:0]          sw_int,
    input  logic                timer_pending,
    input  excp_pkg::int_vec_t  ecfg_lie,
    input  logic                crmd_ie,

    input  csr_pkg::csr_addr_t  rd_addr,
    input  csr_pkg::csr_data_t  bank_rd_data,
    input  csr_pkg::csr_data_t  timer_rd_data,

    output excp_pkg::int_vec_t  estat_is,
    output logic                has_int,
    output csr_pkg::csr_data_t  rd_data
);

    logic [7:0] hw_int_q;
    logic       timer_sel;

    // external lines sampled once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hw_int_q <= '0;
        end else begin
            hw_int_q <= interrupt;
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[excp_pkg::INT_SW_LO +: 2] = sw_int;
        estat_is[excp_pkg::INT_HW_LO +: 8] = hw_int_q;
        estat_is[excp_pkg::INT_TIMER]      = timer_pending;
    end

    assign has_int = crmd_ie && |(estat_is & ecfg_lie);

    // timer block owns 0x40..0x44
    assign timer_sel = (rd_addr >= csr_pkg::CSR_TID) && (rd_addr <= csr_pkg::CSR_TICLR);
    assign rd_data   = timer_sel ? timer_rd_data : bank_rd_data;

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                clk,
    input  logic                rst_n,

    input  csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::csr_data_t  rd_data,

    input  logic                wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_data_t  wr_data,

    input  logic [7:0]          interrupt,

    input  logic                excp_flush,
    input  excp_pkg::ecode_t    excp_code,
    input  csr_pkg::csr_data_t  era_in,
    input  logic                ertn_flush,

    output logic                has_int,
    output csr_pkg::csr_data_t  eentry_out,
    output csr_pkg::csr_data_t  era_out,
    output excp_pkg::plv_t      plv_out,
    output logic [63:0]         timer_64_out,
    output csr_pkg::csr_data_t  tid_out
);

    csr_pkg::csr_data_t bank_rd_data;
    csr_pkg::csr_data_t timer_rd_data;
    logic [1:0]         sw_int;
    excp_pkg::int_vec_t ecfg_lie;
    excp_pkg::int_vec_t estat_is;
    logic               crmd_ie;
    logic               timer_pending;

    csr_bank u_bank (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_addr        (rd_addr),
        .excp_flush     (excp_flush),
        .excp_code      (excp_code),
        .era_in         (era_in),
        .ertn_flush     (ertn_flush),
        .estat_is       (estat_is),
        .bank_rd_data   (bank_rd_data),
        .sw_int         (sw_int),
        .ecfg_lie       (ecfg_lie),
        .crmd_ie        (crmd_ie),
        .plv_out        (plv_out),
        .era_out        (era_out),
        .eentry_out     (eentry_out)
    );

    csr_timer u_timer (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_addr        (rd_addr),
        .timer_rd_data  (timer_rd_data),
        .timer_pending  (timer_pending),
        .timer_64_out   (timer_64_out),
        .tid_out        (tid_out)
    );

    csr_int_unit u_int (
        .clk            (clk),
        .rst_n          (rst_n),
        .interrupt      (interrupt),
        .sw_int         (sw_int),
        .timer_pending  (timer_pending),
        .ecfg_lie       (ecfg_lie),
        .crmd_ie        (crmd_ie),
        .rd_addr        (rd_addr),
        .bank_rd_data   (bank_rd_data),
        .timer_rd_data  (timer_rd_data),
        .estat_is       (estat_is),
        .has_int        (has_int),
        .rd_data        (rd_data)
    );

endmodule

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

    logic               clk = 1'b0;
    logic               rst_n;
    csr_pkg::csr_addr_t rd_addr;
    csr_pkg::csr_data_t rd_data;
    logic               wr_en;
    csr_pkg::csr_addr_t wr_addr;
    csr_pkg::csr_data_t wr_data;
    logic [7:0]         interrupt;
    logic               excp_flush;
    excp_pkg::ecode_t   excp_code;
    csr_pkg::csr_data_t era_in;
    logic               ertn_flush;
    logic               has_int;
    csr_pkg::csr_data_t eentry_out;
    csr_pkg::csr_data_t era_out;
    excp_pkg::plv_t     plv_out;
    logic [63:0]        timer_64_out;
    csr_pkg::csr_data_t tid_out;
    logic [31:0]        rng_state;

    csr_unit uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .interrupt    (interrupt),
        .excp_flush   (excp_flush),
        .excp_code    (excp_code),
        .era_in       (era_in),
        .ertn_flush   (ertn_flush),
        .has_int      (has_int),
        .eentry_out   (eentry_out),
        .era_out      (era_out),
        .plv_out      (plv_out),
        .timer_64_out (timer_64_out),
        .tid_out      (tid_out)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic csr_pkg::csr_data_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_data(input string name, input csr_pkg::csr_data_t exp,
                              input csr_pkg::csr_data_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_plv(input string name, input excp_pkg::plv_t exp,
                             input excp_pkg::plv_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_wide(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // one write strobe, returns at the falling edge after the commit
    task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
        @(negedge clk);
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic wait_estat_bit(input int idx, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        rd_addr = csr_pkg::CSR_ESTAT;
        #1;
        while (!rd_data[idx] && cycles < limit) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!rd_data[idx]) begin
            abort_run($sformatf("timed out waiting for ESTAT bit %0d to set", idx));
        end
    endtask

    task automatic rw_registers();
        csr_pkg::csr_addr_t addrs [6];
        csr_pkg::csr_data_t data;
        csr_pkg::csr_data_t exp;
        csr_pkg::csr_data_t got;
        addrs = '{csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
                  csr_pkg::CSR_SAVE3, csr_pkg::CSR_ERA, csr_pkg::CSR_EENTRY};
        foreach (addrs[i]) begin
            data = rand_word();
            write_csr(addrs[i], data);
            // entry address drops its low 6 bits
            exp = (addrs[i] == csr_pkg::CSR_EENTRY) ? (data & 32'hffff_ffc0) : data;
            read_csr(addrs[i], got);
            check_data($sformatf("rw addr %h", addrs[i]), exp, got);
            if (addrs[i] == csr_pkg::CSR_EENTRY) begin
                check_data("rw eentry_out", exp, eentry_out);
            end
            if (addrs[i] == csr_pkg::CSR_ERA) begin
                check_data("rw era_out", exp, era_out);
            end
        end
        write_csr(14'h3ff, rand_word());
        read_csr(14'h3ff, got);
        check_data("rw unknown addr", 32'h0, got);
    endtask

    task automatic exception_round_trip();
        csr_pkg::csr_data_t era_val;
        csr_pkg::csr_data_t tmp;
        excp_pkg::ecode_t   code;
        csr_pkg::csr_data_t got;
        era_val = rand_word();
        tmp     = rand_word();
        code    = tmp[5:0];
        // level 3, enable 1
        write_csr(csr_pkg::CSR_CRMD, 32'h7);
        write_csr(csr_pkg::CSR_PRMD, 32'h0);
        @(negedge clk);
        excp_flush = 1'b1;
        excp_code  = code;
        era_in     = era_val;
        @(negedge clk);
        excp_flush = 1'b0;
        #1;
        check_plv("excp plv_out", 2'd0, plv_out);
        check_data("excp era_out", era_val, era_out);
        read_csr(csr_pkg::CSR_CRMD, got);
        check_data("excp crmd", 32'h0, got);
        read_csr(csr_pkg::CSR_PRMD, got);
        check_data("excp prmd", 32'h7, got);
        read_csr(csr_pkg::CSR_ESTAT, got);
        check_data("excp ecode", {26'b0, code}, {26'b0, got[21:16]});
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
        #1;
        check_plv("ertn plv_out", 2'd3, plv_out);
        read_csr(csr_pkg::CSR_CRMD, got);
        check_data("ertn crmd", 32'h7, got);
    endtask

    task automatic interrupt_masking();
        write_csr(csr_pkg::CSR_CRMD, 32'h4);
        write_csr(csr_pkg::CSR_ECFG, 32'h0);
        @(negedge clk);
        interrupt = 8'h08;
        repeat (3) @(negedge clk);
        #1;
        check_bit("int hw masked", 1'b0, has_int);
        write_csr(csr_pkg::CSR_ECFG, 32'h1 << (excp_pkg::INT_HW_LO + 3));
        #1;
        check_bit("int hw unmasked", 1'b1, has_int);
        // line is registered once
        @(negedge clk);
        interrupt = 8'h00;
        #1;
        check_bit("int hw held", 1'b1, has_int);
        @(negedge clk);
        #1;
        check_bit("int hw dropped", 1'b0, has_int);
        @(negedge clk);
        interrupt = 8'h08;
        @(negedge clk);
        #1;
        check_bit("int hw back", 1'b1, has_int);
        write_csr(csr_pkg::CSR_CRMD, 32'h0);
        #1;
        check_bit("int hw ie off", 1'b0, has_int);
        @(negedge clk);
        interrupt = 8'h00;
        write_csr(csr_pkg::CSR_ECFG, 32'h0);
        write_csr(csr_pkg::CSR_CRMD, 32'h4);
        write_csr(csr_pkg::CSR_ESTAT, 32'h1 << excp_pkg::INT_SW_LO);
        #1;
        check_bit("int sw masked", 1'b0, has_int);
        write_csr(csr_pkg::CSR_ECFG, 32'h1 << excp_pkg::INT_SW_LO);
        #1;
        check_bit("int sw unmasked", 1'b1, has_int);
        write_csr(csr_pkg::CSR_CRMD, 32'h0);
        #1;
        check_bit("int sw ie off", 1'b0, has_int);
        write_csr(csr_pkg::CSR_ESTAT, 32'h0);
        write_csr(csr_pkg::CSR_ECFG, 32'h0);
    endtask

    task automatic oneshot_timer();
        csr_pkg::csr_data_t got;
        // initial value 4, periodic 0, enable 1
        write_csr(csr_pkg::CSR_TCFG, (32'd4 << 2) | 32'h1);
        read_csr(csr_pkg::CSR_TVAL, got);
        check_data("timer first count", (32'd4 << 2) - 32'd1, got);
        wait_estat_bit(excp_pkg::INT_TIMER, 40);
        read_csr(csr_pkg::CSR_TVAL, got);
        check_data("timer stopped", 32'h0, got);
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT, got);
        check_bit("timer cleared", 1'b0, got[excp_pkg::INT_TIMER]);
        write_csr(csr_pkg::CSR_TCFG, 32'h0);
    endtask

    task automatic free_counter();
        logic [63:0]        count_a;
        logic [63:0]        count_b;
        csr_pkg::csr_data_t tid;
        csr_pkg::csr_data_t got;
        @(negedge clk);
        count_a = timer_64_out;
        repeat (7) @(negedge clk);
        count_b = timer_64_out;
        check_wide("counter step", 64'd7, count_b - count_a);
        tid = rand_word();
        write_csr(csr_pkg::CSR_TID, tid);
        read_csr(csr_pkg::CSR_TID, got);
        check_data("counter tid read", tid, got);
        check_data("counter tid_out", tid, tid_out);
    endtask

    initial begin
        rst_n      = 1'b0;
        rd_addr    = '0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        interrupt  = '0;
        excp_flush = 1'b0;
        excp_code  = '0;
        era_in     = '0;
        ertn_flush = 1'b0;
        rng_state  = 32'h11999989;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_wide("reset counter", 64'd0, timer_64_out);
        check_bit("reset has_int", 1'b0, has_int);
        check_plv("reset plv", 2'd0, plv_out);
        rw_registers();
        exception_round_trip();
        interrupt_masking();
        oneshot_timer();
        free_counter();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
common/csr_pkg.sv
common/excp_pkg.sv
csr/csr_bank.sv
csr/csr_timer.sv
rtl/csr_int_unit.sv
rtl/csr_unit.sv
dv/csr_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps -f list.f --top-module csr_unit_tb -o csr_unit_sim &&
./obj_dir/csr_unit_sim ||
{ echo "build or simulation failed" >&2; exit 1; }
